//--- floo_pkg.sv
`default_nettype none

package floo_pkg;

  // ----------------------------------------------------------
  // Router geometry
  // ----------------------------------------------------------

  // Number of router ports, one per direction plus the local port
  localparam int unsigned NumRoutes = 5;

  // Port indices
  // North points to higher y, East to higher x
  localparam int unsigned RouteNorth = 0;
  localparam int unsigned RouteEast  = 1;
  localparam int unsigned RouteSouth = 2;
  localparam int unsigned RouteWest  = 3;
  localparam int unsigned RouteLocal = 4;

  // Width of the index used to pick one of the routes
  localparam int unsigned SelWidth = $clog2(NumRoutes);

  // Width of a single x or y coordinate
  localparam int unsigned CoordWidth = 3;

  // Reduction tag width
  localparam int unsigned RedIdWidth = 4;

  // Payload sizing
  localparam int unsigned DataWidth = 32;
  localparam int unsigned RespWidth = 2;
  localparam int unsigned PadWidth  = DataWidth - RespWidth;

  // ----------------------------------------------------------
  // Header types
  // ----------------------------------------------------------

  typedef logic [SelWidth-1:0] sel_t;

  // Node or router coordinate
  typedef struct packed {
    logic [CoordWidth-1:0] x;
    logic [CoordWidth-1:0] y;
  } id_t;

  // Rectangle of nodes taking part in the reduction, bounds inclusive
  typedef struct packed {
    logic [CoordWidth-1:0] x_min;
    logic [CoordWidth-1:0] x_max;
    logic [CoordWidth-1:0] y_min;
    logic [CoordWidth-1:0] y_max;
  } region_t;

  typedef enum logic [1:0] {
    SelectAW = 2'd0,
    LSBAnd   = 2'd1,
    CollectB = 2'd2
  } collect_op_e;

  typedef struct packed {
    id_t                   dst_id;
    region_t               region;
    logic [RedIdWidth-1:0] red_id;
    collect_op_e           collective_op;
  } hdr_t;

  // ----------------------------------------------------------
  // Payload types
  // ----------------------------------------------------------

  // AXI style response codes
  typedef enum logic [RespWidth-1:0] {
    RespOkay   = 2'd0,
    RespExOkay = 2'd1,
    RespSlvErr = 2'd2,
    RespDecErr = 2'd3
  } resp_e;

  // W view, plain write data
  typedef struct packed {
    logic [DataWidth-1:0] data;
  } w_payload_t;

  // B view, response sits in the lowest bits
  typedef struct packed {
    logic [PadWidth-1:0] pad;
    resp_e               resp;
  } b_payload_t;

  // Same word read as W data or B response, depending on collective_op
  typedef union packed {
    w_payload_t w;
    b_payload_t b;
  } payload_u;

  typedef struct packed {
    hdr_t     hdr;
    payload_u payload;
  } flit_t;

  // One bit per input port
  typedef logic [NumRoutes-1:0] route_mask_t;

endpackage

`default_nettype wire

//--- floo_reduction_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module floo_reduction_arbiter (
  input  floo_pkg::id_t                             xy_id_i,
  input  floo_pkg::route_mask_t                     valid_i,
  output floo_pkg::route_mask_t                     ready_o,
  input  floo_pkg::flit_t [floo_pkg::NumRoutes-1:0] data_i,
  output logic                                      valid_o,
  input  logic                                      ready_i,
  output floo_pkg::flit_t                           data_o
);

  // Expected participants and handshake per input
  floo_pkg::route_mask_t [floo_pkg::NumRoutes-1:0] in_route_mask;
  floo_pkg::route_mask_t                           red_valid_in;
  floo_pkg::route_mask_t [floo_pkg::NumRoutes-1:0] ready_out;

  floo_pkg::sel_t input_sel;

  // Merge candidates, all built in parallel
  floo_pkg::flit_t data_forward;
  floo_pkg::flit_t data_lsb_and;
  floo_pkg::flit_t data_collect_b;

  floo_pkg::collect_op_e incoming_red_op;

  for (genvar i = 0; i < floo_pkg::NumRoutes; i++) begin : gen_route
    floo_route_xymask i_route_xymask (
      .channel_i   ( data_i[i]        ),
      .xy_id_i     ( xy_id_i          ),
      .route_sel_o ( in_route_mask[i] )
    );

    floo_reduction_sync #(
      .Index ( i )
    ) i_reduction_sync (
      .data_i          ( data_i           ),
      .valid_i         ( valid_i          ),
      .in_route_mask_i ( in_route_mask[i] ),
      .ready_i         ( ready_i          ),
      .valid_o         ( red_valid_in[i]  ),
      .ready_o         ( ready_out[i]     )
    );
  end

  // Lowest ready input wins, scan from the top so the last hit is the lowest
  always_comb begin : gen_tzc
    input_sel = '0;
    for (int i = floo_pkg::NumRoutes - 1; i >= 0; i--) begin
      if (red_valid_in[i]) begin
        input_sel = floo_pkg::sel_t'(i);
      end
    end
  end

  assign incoming_red_op = data_i[input_sel].hdr.collective_op;

  // ----------------------------------------------------------
  // Reduction operations
  // ----------------------------------------------------------

  // Plain forward of the chosen flit
  assign data_forward = data_i[input_sel];

  // AND of data bit 0 over the whole set
  always_comb begin : gen_lsb_and
    logic lsb;
    lsb = 1'b1;
    for (int i = 0; i < floo_pkg::NumRoutes; i++) begin
      if (in_route_mask[input_sel][i]) begin
        lsb &= data_i[i].payload.w.data[0];
      end
    end
    data_lsb_and = data_i[input_sel];
    data_lsb_and.payload.w.data[0] = lsb;
  end

  // First slave error in port order overrides the chosen flit
  always_comb begin : gen_collect_b
    logic found;
    found = 1'b0;
    data_collect_b = data_i[input_sel];
    for (int i = 0; i < floo_pkg::NumRoutes; i++) begin
      if (in_route_mask[input_sel][i] && !found &&
          data_i[i].payload.b.resp == floo_pkg::RespSlvErr) begin
        data_collect_b = data_i[i];
        found = 1'b1;
      end
    end
  end

  // Pick the result that matches the operation in the header
  always_comb begin : gen_out_sel
    case (incoming_red_op)
      floo_pkg::LSBAnd:   data_o = data_lsb_and;
      floo_pkg::CollectB: data_o = data_collect_b;
      default:            data_o = data_forward;
    endcase
  end

  // Handshake follows the selected synchronizer
  assign valid_o = red_valid_in[input_sel];
  assign ready_o = ready_out[input_sel];

endmodule

`default_nettype wire

//--- floo_reduction_out_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module floo_reduction_out_buffer (
  input  logic            clk_i,
  input  logic            arst_n_i,
  input  logic            valid_i,
  output logic            ready_o,
  input  floo_pkg::flit_t data_i,
  output logic            valid_o,
  input  logic            ready_i,
  output floo_pkg::flit_t data_o
);

  // Two slots used as a tiny circular FIFO
  floo_pkg::flit_t mem_q [2];

  logic       wr_ptr_q;
  logic       rd_ptr_q;
  logic [1:0] count_q;
  logic [1:0] count_d;
  logic       ready_q;

  logic push;
  logic pop;

  assign push = valid_i && ready_o;
  assign pop  = valid_o && ready_i;

  // Occupancy after this cycle
  assign count_d = count_q + {1'b0, push} - {1'b0, pop};

  // ----------------------------------------------------------
  // Control state
  // ----------------------------------------------------------

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      count_q  <= 2'd0;
      ready_q  <= 1'b1;
    end else begin
      if (push) begin
        wr_ptr_q <= ~wr_ptr_q;
      end
      if (pop) begin
        rd_ptr_q <= ~rd_ptr_q;
      end
      count_q <= count_d;
      // Ready is registered, not full after this cycle
      ready_q <= (count_d != 2'd2);
    end
  end

  // Payload storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  assign ready_o = ready_q;
  assign valid_o = (count_q != 2'd0);
  assign data_o  = mem_q[rd_ptr_q];

endmodule

`default_nettype wire

//--- floo_reduction_sync.sv
`timescale 1ns/1ps
`default_nettype none

module floo_reduction_sync #(
  // Input port this synchronizer speaks for
  parameter int unsigned Index = 0
) (
  input  floo_pkg::flit_t [floo_pkg::NumRoutes-1:0] data_i,
  input  floo_pkg::route_mask_t                     valid_i,
  input  floo_pkg::route_mask_t                     in_route_mask_i,
  input  logic                                      ready_i,
  output logic                                      valid_o,
  output floo_pkg::route_mask_t                     ready_o
);

  // Header of our own flit, the reference for all tag compares
  floo_pkg::hdr_t own_hdr;

  assign own_hdr = data_i[Index].hdr;

  // ----------------------------------------------------------
  // Participant check
  // ----------------------------------------------------------

  always_comb begin : gen_complete
    // Our own input must be valid and part of its own set
    valid_o = valid_i[Index] & in_route_mask_i[Index];
    for (int j = 0; j < floo_pkg::NumRoutes; j++) begin
      if (in_route_mask_i[j]) begin
        // Missing participant, set is not complete yet
        if (!valid_i[j]) begin
          valid_o = 1'b0;
        end
        // Different reduction on that port, wait for ours
        if (data_i[j].hdr.dst_id != own_hdr.dst_id ||
            data_i[j].hdr.red_id != own_hdr.red_id ||
            data_i[j].hdr.collective_op != own_hdr.collective_op) begin
          valid_o = 1'b0;
        end
      end
    end
  end

  // All participants are consumed together on the output transfer
  assign ready_o = (ready_i && valid_o) ? in_route_mask_i : '0;

endmodule

`default_nettype wire

//--- floo_reduction_unit.sv
`timescale 1ns/1ps
`default_nettype none

module floo_reduction_unit (
  input  logic                                      clk_i,
  input  logic                                      arst_n_i,
  // Coordinate of this router
  input  floo_pkg::id_t                             xy_id_i,
  // Input ports, one per route
  input  floo_pkg::route_mask_t                     valid_i,
  output floo_pkg::route_mask_t                     ready_o,
  input  floo_pkg::flit_t [floo_pkg::NumRoutes-1:0] data_i,
  // Reduced output stream
  output logic                                      valid_o,
  input  logic                                      ready_i,
  output floo_pkg::flit_t                           data_o
);

  // Merged stream between arbiter and buffer
  logic            red_valid;
  logic            red_ready;
  floo_pkg::flit_t red_data;

  // Combinational merge of the participants
  floo_reduction_arbiter i_reduction_arbiter (
    .xy_id_i ( xy_id_i   ),
    .valid_i ( valid_i   ),
    .ready_o ( ready_o   ),
    .data_i  ( data_i    ),
    .valid_o ( red_valid ),
    .ready_i ( red_ready ),
    .data_o  ( red_data  )
  );

  // One cycle of latency, two flits of slack
  floo_reduction_out_buffer i_out_buffer (
    .clk_i    ( clk_i     ),
    .arst_n_i ( arst_n_i  ),
    .valid_i  ( red_valid ),
    .ready_o  ( red_ready ),
    .data_i   ( red_data  ),
    .valid_o  ( valid_o   ),
    .ready_i  ( ready_i   ),
    .data_o   ( data_o    )
  );

endmodule

`default_nettype wire

//--- floo_route_xymask.sv
`timescale 1ns/1ps
`default_nettype none

module floo_route_xymask (
  input  floo_pkg::flit_t       channel_i,
  input  floo_pkg::id_t         xy_id_i,
  output floo_pkg::route_mask_t route_sel_o
);

  floo_pkg::id_t     dst;
  floo_pkg::region_t reg_r;

  // Router position against the region bounds
  logic in_x_range;
  logic in_y_range;

  assign dst   = channel_i.hdr.dst_id;
  assign reg_r = channel_i.hdr.region;

  assign in_x_range = (xy_id_i.x >= reg_r.x_min) && (xy_id_i.x <= reg_r.x_max);
  assign in_y_range = (xy_id_i.y >= reg_r.y_min) && (xy_id_i.y <= reg_r.y_max);

  // ----------------------------------------------------------
  // Backward XY mask
  // ----------------------------------------------------------

  // X-first routing toward the root means a row gathers its nodes first
  // West neighbours exist in the region and we are not yet past the root column
  assign route_sel_o[floo_pkg::RouteWest] = in_y_range && (xy_id_i.x <= dst.x) &&
                                            (reg_r.x_min < xy_id_i.x);

  // Mirror case, traffic from the east heads west toward the root column
  assign route_sel_o[floo_pkg::RouteEast] = in_y_range && (xy_id_i.x >= dst.x) &&
                                            (reg_r.x_max > xy_id_i.x);

  // Only the root column merges rows in y, so y traffic appears there alone
  assign route_sel_o[floo_pkg::RouteSouth] = (xy_id_i.x == dst.x) && (xy_id_i.y <= dst.y) &&
                                             (reg_r.y_min < xy_id_i.y);

  assign route_sel_o[floo_pkg::RouteNorth] = (xy_id_i.x == dst.x) && (xy_id_i.y >= dst.y) &&
                                             (reg_r.y_max > xy_id_i.y);

  // Our own endpoint contributes when it lies inside the region
  assign route_sel_o[floo_pkg::RouteLocal] = in_x_range && in_y_range;

endmodule

`default_nettype wire

//--- list.f
floo_pkg.sv
floo_route_xymask.sv
floo_reduction_sync.sv
floo_reduction_arbiter.sv
floo_reduction_out_buffer.sv
floo_reduction_unit.sv
tb_floo_reduction_unit.sv

//--- run.sh
#!/bin/sh
# Build and run the reduction unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -f list.f \
  --top-module tb_floo_reduction_unit -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

if grep -q "SIMULATION PASSED" sim.log; then
  exit 0
else
  exit 1
fi

//--- tb_floo_reduction_unit.sv
`timescale 1ns/1ps
`default_nettype none

module tb_floo_reduction_unit;

  localparam int ClkPeriod   = 4;
  localparam int ResetCycles = 10;
  localparam int OfferWait   = 20;
  localparam int DrainWait   = 10;
  localparam int NumRounds   = 8;

  // One offer plus drain with slack for the idle cycles in between
  localparam int RoundCycles = OfferWait + DrainWait + 3;
  // Reset, local, row rounds, three error rounds, incomplete set, back-pressure
  localparam int TestCycles  = ResetCycles + 4 + RoundCycles * (1 + NumRounds + 3)
                             + (28 + RoundCycles) + (10 + 3 * RoundCycles);
  localparam int WatchdogCycles = TestCycles + 100;

  logic                                      clk;
  logic                                      arst_n;
  floo_pkg::id_t                             xy_id;
  floo_pkg::route_mask_t                     in_valid;
  floo_pkg::route_mask_t                     in_ready;
  floo_pkg::flit_t [floo_pkg::NumRoutes-1:0] in_data;
  logic                                      out_valid;
  logic                                      out_ready;
  floo_pkg::flit_t                           out_data;

  // Expected output flits in acceptance order
  floo_pkg::flit_t exp_q [$];
  logic            valid_at_accept;
  int              checks;
  int              errors;
  int              out_count;

  floo_reduction_unit dut0 (
    .clk_i    ( clk       ),
    .arst_n_i ( arst_n    ),
    .xy_id_i  ( xy_id     ),
    .valid_i  ( in_valid  ),
    .ready_o  ( in_ready  ),
    .data_i   ( in_data   ),
    .valid_o  ( out_valid ),
    .ready_i  ( out_ready ),
    .data_o   ( out_data  )
  );

  initial begin : clock_gen
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  // ----------------------------------------------------------
  // Helpers and reference model
  // ----------------------------------------------------------

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error: %s is 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  function automatic floo_pkg::route_mask_t port_bit(input int p);
    floo_pkg::route_mask_t m;
    m = '0;
    m[p] = 1'b1;
    return m;
  endfunction

  function automatic floo_pkg::id_t make_id(input int x, input int y);
    floo_pkg::id_t id;
    id.x = 3'(x);
    id.y = 3'(y);
    return id;
  endfunction

  function automatic floo_pkg::region_t make_region(input int x0, input int x1,
                                                    input int y0, input int y1);
    floo_pkg::region_t r;
    r.x_min = 3'(x0);
    r.x_max = 3'(x1);
    r.y_min = 3'(y0);
    r.y_max = 3'(y1);
    return r;
  endfunction

  function automatic floo_pkg::flit_t make_flit(input floo_pkg::id_t dst,
                                                input floo_pkg::region_t region,
                                                input logic [3:0] red_id,
                                                input floo_pkg::collect_op_e op,
                                                input logic [31:0] word);
    floo_pkg::flit_t f;
    f.hdr.dst_id        = dst;
    f.hdr.region        = region;
    f.hdr.red_id        = red_id;
    f.hdr.collective_op = op;
    f.payload.w.data    = word;
    return f;
  endfunction

  // Inputs that feed a flit heading to root d from region R at router r
  function automatic floo_pkg::route_mask_t expected_mask(input floo_pkg::hdr_t h,
                                                          input floo_pkg::id_t r);
    floo_pkg::route_mask_t m;
    logic                  x_in;
    logic                  y_in;
    x_in = (r.x >= h.region.x_min) && (r.x <= h.region.x_max);
    y_in = (r.y >= h.region.y_min) && (r.y <= h.region.y_max);
    m = '0;
    m[floo_pkg::RouteWest]  = y_in && (r.x <= h.dst_id.x) && (h.region.x_min < r.x);
    m[floo_pkg::RouteEast]  = y_in && (r.x >= h.dst_id.x) && (h.region.x_max > r.x);
    m[floo_pkg::RouteSouth] = (r.x == h.dst_id.x) && (r.y <= h.dst_id.y) &&
                              (h.region.y_min < r.y);
    m[floo_pkg::RouteNorth] = (r.x == h.dst_id.x) && (r.y >= h.dst_id.y) &&
                              (h.region.y_max > r.y);
    m[floo_pkg::RouteLocal] = x_in && y_in;
    return m;
  endfunction

  // Returns 1 when some reduction is complete and hands back its ready set and merged flit
  function automatic logic model_reduce(input floo_pkg::flit_t [floo_pkg::NumRoutes-1:0] f,
                                        input floo_pkg::route_mask_t v,
                                        input floo_pkg::id_t r,
                                        output floo_pkg::route_mask_t mask,
                                        output floo_pkg::flit_t out);
    floo_pkg::route_mask_t m;
    logic                  found;
    logic                  rdy;
    logic                  lsb;
    int                    sel;
    found = 1'b0;
    sel   = 0;
    mask  = '0;
    out   = '0;
    for (int i = 0; i < floo_pkg::NumRoutes; i++) begin
      m   = expected_mask(f[i].hdr, r);
      rdy = v[i] && m[i];
      for (int j = 0; j < floo_pkg::NumRoutes; j++) begin
        if (m[j] && (!v[j] || f[j].hdr.dst_id != f[i].hdr.dst_id ||
            f[j].hdr.red_id != f[i].hdr.red_id ||
            f[j].hdr.collective_op != f[i].hdr.collective_op)) begin
          rdy = 1'b0;
        end
      end
      // Lowest ready index wins
      if (rdy && !found) begin
        found = 1'b1;
        sel   = i;
        mask  = m;
      end
    end
    if (found) begin
      out = f[sel];
      case (out.hdr.collective_op)
        floo_pkg::LSBAnd: begin
          lsb = 1'b1;
          for (int j = 0; j < floo_pkg::NumRoutes; j++) begin
            if (mask[j]) lsb = lsb & f[j].payload.w.data[0];
          end
          out.payload.w.data[0] = lsb;
        end
        floo_pkg::CollectB: begin
          // Walk downward so the lowest slave error is kept
          for (int j = floo_pkg::NumRoutes - 1; j >= 0; j--) begin
            if (mask[j] && f[j].payload.b.resp == floo_pkg::RespSlvErr) out = f[j];
          end
        end
        default: ;
      endcase
    end
    return found;
  endfunction

  // ----------------------------------------------------------
  // Stimulus and handshake tasks
  // ----------------------------------------------------------

  task automatic drive(input floo_pkg::flit_t [floo_pkg::NumRoutes-1:0] flits,
                       input floo_pkg::route_mask_t valids);
    @(negedge clk);
    in_data  = flits;
    in_valid = valids;
  endtask

  // Starts at a falling edge and samples ready_o mid cycle
  task automatic await_accept(input int max_cycles, output logic accepted);
    floo_pkg::route_mask_t exp_ready;
    floo_pkg::route_mask_t seen;
    floo_pkg::flit_t       exp_flit;
    logic                  model_ok;
    int                    n;
    model_ok = model_reduce(in_data, in_valid, xy_id, exp_ready, exp_flit);
    accepted = 1'b0;
    seen     = '0;
    n        = 0;
    while (!accepted && n < max_cycles) begin
      #1;
      if (in_ready != '0) begin
        accepted        = 1'b1;
        seen            = in_ready;
        valid_at_accept = out_valid;
        if (!model_ok) begin
          $display("Inputs were accepted although no participant set was complete");
          errors++;
        end
        check("ready_o", 64'(in_ready), 64'(exp_ready));
        exp_q.push_back(exp_flit);
      end
      @(negedge clk);
      n++;
    end
    // Consumed participants drop their valid
    in_valid = in_valid & ~seen;
  endtask

  task automatic offer(input floo_pkg::flit_t [floo_pkg::NumRoutes-1:0] flits,
                       input floo_pkg::route_mask_t valids);
    logic accepted;
    drive(flits, valids);
    await_accept(OfferWait, accepted);
    if (!accepted) begin
      $display("No reduction was accepted within %0d cycles", OfferWait);
      errors++;
    end
  endtask

  // Sampled after the monitor so the queue size is settled
  task automatic drain();
    int n;
    n = 0;
    @(negedge clk);
    #2;
    while (exp_q.size() != 0 && n < DrainWait) begin
      @(negedge clk);
      #2;
      n++;
    end
    if (exp_q.size() != 0) begin
      $display("%0d expected output flits never appeared", exp_q.size());
      errors++;
      exp_q.delete();
    end
  endtask

  // Every output transfer is compared in order
  initial begin : out_monitor
    floo_pkg::flit_t exp_flit;
    forever begin
      @(negedge clk);
      #1;
      if (arst_n && out_valid && out_ready) begin
        out_count++;
        if (exp_q.size() == 0) begin
          $display("An output flit appeared while no reduction was pending");
          errors++;
        end else begin
          exp_flit = exp_q.pop_front();
          check("data_o", 64'(out_data), 64'(exp_flit));
        end
      end
    end
  end

  // ----------------------------------------------------------
  // Directed tests
  // ----------------------------------------------------------

  task automatic test_reset();
    repeat (ResetCycles) begin
      @(posedge clk);
      #1;
      check("valid_o", 64'(out_valid), 64'd0);
      check("ready_o", 64'(in_ready), 64'd0);
    end
    @(negedge clk);
    arst_n = 1'b1;
    repeat (3) begin
      #1;
      check("valid_o", 64'(out_valid), 64'd0);
      check("ready_o", 64'(in_ready), 64'd0);
      @(negedge clk);
    end
  endtask

  // Region and root are this router so only Local takes part
  task automatic test_local_select();
    floo_pkg::flit_t [floo_pkg::NumRoutes-1:0] flits;
    flits = '0;
    flits[floo_pkg::RouteLocal] = make_flit(make_id(2, 2), make_region(2, 2, 2, 2), 4'h1,
                                            floo_pkg::SelectAW, $urandom());
    offer(flits, port_bit(floo_pkg::RouteLocal));
    check("valid_o at acceptance", 64'(valid_at_accept), 64'd0);
    // One cycle later the flit sits unchanged on the output
    #1;
    check("valid_o", 64'(out_valid), 64'd1);
    check("data_o unchanged", 64'(out_data), 64'(flits[floo_pkg::RouteLocal]));
    drain();
  endtask

  // Root east of us on row 2 with West and Local contributing
  task automatic test_row_lsb_and();
    floo_pkg::flit_t [floo_pkg::NumRoutes-1:0] flits;
    for (int r = 0; r < NumRounds; r++) begin
      flits = '0;
      flits[floo_pkg::RouteWest]  = make_flit(make_id(3, 2), make_region(0, 2, 2, 2), 4'(r),
                                              floo_pkg::LSBAnd, $urandom());
      flits[floo_pkg::RouteLocal] = make_flit(make_id(3, 2), make_region(0, 2, 2, 2), 4'(r),
                                              floo_pkg::LSBAnd, $urandom());
      // Bit 0 pair walks through all four combinations
      flits[floo_pkg::RouteWest].payload.w.data[0]  = r[0];
      flits[floo_pkg::RouteLocal].payload.w.data[0] = r[1];
      offer(flits, port_bit(floo_pkg::RouteWest) | port_bit(floo_pkg::RouteLocal));
      drain();
    end
  endtask

  // All five ports feed the root at this router
  task automatic collect_round(input floo_pkg::route_mask_t errs, input logic [3:0] red_id);
    floo_pkg::flit_t [floo_pkg::NumRoutes-1:0] flits;
    logic [31:0]                               word;
    for (int i = 0; i < floo_pkg::NumRoutes; i++) begin
      word      = $urandom();
      word[1:0] = errs[i] ? floo_pkg::RespSlvErr : floo_pkg::RespOkay;
      flits[i]  = make_flit(make_id(2, 2), make_region(1, 3, 1, 3), red_id,
                            floo_pkg::CollectB, word);
    end
    offer(flits, '1);
    drain();
  endtask

  task automatic test_collect_b();
    collect_round(port_bit(floo_pkg::RouteSouth), 4'h5);
    collect_round(port_bit(floo_pkg::RouteEast) | port_bit(floo_pkg::RouteWest), 4'h6);
    collect_round('0, 4'h7);
  endtask

  task automatic test_incomplete_set();
    floo_pkg::flit_t [floo_pkg::NumRoutes-1:0] flits;
    logic                                      accepted;
    int                                        count_before;
    flits = '0;
    flits[floo_pkg::RouteWest]  = make_flit(make_id(3, 2), make_region(0, 2, 2, 2), 4'h9,
                                            floo_pkg::LSBAnd, $urandom());
    flits[floo_pkg::RouteLocal] = make_flit(make_id(3, 2), make_region(0, 2, 2, 2), 4'h9,
                                            floo_pkg::LSBAnd, $urandom());
    // West is still missing
    drive(flits, port_bit(floo_pkg::RouteLocal));
    repeat (20) begin
      #1;
      check("valid_o", 64'(out_valid), 64'd0);
      check("ready_o", 64'(in_ready), 64'd0);
      @(negedge clk);
    end
    count_before = out_count;
    in_valid = in_valid | port_bit(floo_pkg::RouteWest);
    await_accept(OfferWait, accepted);
    check("completed set accepted", 64'(accepted), 64'd1);
    drain();
    repeat (5) @(negedge clk);
    check("merged flit count", 64'(out_count - count_before), 64'd1);
  endtask

  task automatic test_back_pressure();
    floo_pkg::flit_t [floo_pkg::NumRoutes-1:0] flits;
    logic                                      accepted;
    @(negedge clk);
    out_ready = 1'b0;
    for (int k = 0; k < 3; k++) begin
      flits = '0;
      flits[floo_pkg::RouteLocal] = make_flit(make_id(2, 2), make_region(2, 2, 2, 2),
                                              4'(k + 2), floo_pkg::SelectAW, $urandom());
      drive(flits, port_bit(floo_pkg::RouteLocal));
      // Buffer takes two and the third waits at the input
      await_accept(k < 2 ? OfferWait : 8, accepted);
      check("accepted under back-pressure", 64'(accepted), k < 2 ? 64'd1 : 64'd0);
    end
    out_ready = 1'b1;
    await_accept(OfferWait, accepted);
    check("accepted after release", 64'(accepted), 64'd1);
    drain();
  endtask

  // ----------------------------------------------------------
  // Run control
  // ----------------------------------------------------------

  initial begin : main
    void'($urandom(32'h19e4d3ea));
    checks    = 0;
    errors    = 0;
    out_count = 0;
    arst_n    = 1'b0;
    xy_id     = make_id(2, 2);
    in_valid  = '0;
    in_data   = '0;
    out_ready = 1'b1;
    valid_at_accept = 1'b0;
    test_reset();
    test_local_select();
    test_row_lsb_and();
    test_collect_b();
    test_incomplete_set();
    test_back_pressure();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    #(WatchdogCycles * ClkPeriod);
    $display("Watchdog expired after %0d cycles, the tests did not finish", WatchdogCycles);
    $display("Checks: %0d, errors: %0d", checks, errors);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

`default_nettype wire
